// File: chiplet_tx.f
+incdir+hw
hw/chiplet_tx_pkg.sv
hw/msg_table.sv
hw/pkt_buffer.sv
hw/flit_counter.sv
hw/tx_fsm.sv
hw/flit_queue.sv
hw/chiplet_tx.sv
tests/chiplet_tx_tb.sv

// File: hw/chiplet_tx.sv
`timescale 1ns/1ns

module chiplet_tx #(
    parameter chiplet_tx_pkg::node_id_t node_id = 4'h5
) (
    input  logic                       clk,
    input  logic                       n_rst,
    input  chiplet_tx_pkg::buf_wr_t    buf_wr,
    input  chiplet_tx_pkg::slot_cfg_t  slot_cfg,
    input  logic                       send_req,
    input  chiplet_tx_pkg::slot_id_t   send_slot,
    output logic                       send_ack,
    output logic                       flit_valid,
    output chiplet_tx_pkg::flit_t      flit,
    input  logic                       flit_ready
);

    logic                      sel_valid;
    chiplet_tx_pkg::slot_id_t  sel_slot;
    chiplet_tx_pkg::buf_addr_t sel_start;
    logic                      sel_take;

    chiplet_tx_pkg::buf_addr_t rd_addr;
    chiplet_tx_pkg::word_t     rd_data;

    logic                      cnt_clear;
    logic                      cnt_en;
    chiplet_tx_pkg::pkt_len_t  cnt_limit;
    chiplet_tx_pkg::pkt_len_t  count;
    logic                      done;

    logic                      full;
    logic                      push;
    chiplet_tx_pkg::flit_t     push_flit;

    msg_table u_msg_table (
        .clk       (clk),
        .n_rst     (n_rst),
        .slot_cfg  (slot_cfg),
        .send_req  (send_req),
        .send_slot (send_slot),
        .send_ack  (send_ack),
        .sel_take  (sel_take),
        .sel_valid (sel_valid),
        .sel_slot  (sel_slot),
        .sel_start (sel_start)
    );

    pkt_buffer u_pkt_buffer (
        .clk     (clk),
        .n_rst   (n_rst),
        .buf_wr  (buf_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    flit_counter u_flit_counter (
        .clk   (clk),
        .n_rst (n_rst),
        .clear (cnt_clear),
        .en    (cnt_en),
        .limit (cnt_limit),
        .count (count),
        .done  (done)
    );

    tx_fsm #(
        .node_id (node_id)
    ) u_tx_fsm (
        .clk       (clk),
        .n_rst     (n_rst),
        .sel_valid (sel_valid),
        .sel_slot  (sel_slot),
        .sel_start (sel_start),
        .sel_take  (sel_take),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .cnt_clear (cnt_clear),
        .cnt_en    (cnt_en),
        .cnt_limit (cnt_limit),
        .count     (count),
        .done      (done),
        .full      (full),
        .push      (push),
        .push_flit (push_flit)
    );

    flit_queue u_flit_queue (
        .clk        (clk),
        .n_rst      (n_rst),
        .push       (push),
        .push_flit  (push_flit),
        .full       (full),
        .flit_valid (flit_valid),
        .flit       (flit),
        .flit_ready (flit_ready)
    );

endmodule

// File: hw/chiplet_tx_consts.svh
`ifndef CHIPLET_TX_CONSTS_SVH
`define CHIPLET_TX_CONSTS_SVH

// ##########################################################################
// datapath widths.
// ##########################################################################

`define WORD_W 32
`define BUF_AW 6
`define SLOT_W 2
`define NODE_W 4
`define VC_W 2

// ##########################################################################
// packet header and queue sizing.
// ##########################################################################

// the length field holds the number of payload words after the header.
`define LEN_W 4
`define LEN_LSB 0

// entries in the output queue toward the switch.
`define QUEUE_DEPTH 4

`endif

// File: hw/chiplet_tx_pkg.sv
`include "chiplet_tx_consts.svh"

package chiplet_tx_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`BUF_AW-1:0] buf_addr_t;
    typedef logic [`SLOT_W-1:0] slot_id_t;
    typedef logic [`LEN_W-1:0]  pkt_len_t;
    typedef logic [`NODE_W-1:0] node_id_t;
    typedef logic [`VC_W-1:0]   vc_t;

    // one flit as it leaves the endpoint.
    typedef struct packed {
        vc_t      vc;
        slot_id_t id;
        node_id_t src;
        word_t    payload;
    } flit_t;

    typedef struct packed {
        logic      en;
        buf_addr_t addr;
        word_t     data;
    } buf_wr_t;

    // host write of one message table entry.
    typedef struct packed {
        logic      en;
        slot_id_t  slot;
        buf_addr_t start;
    } slot_cfg_t;

endpackage

// File: hw/flit_counter.sv
`timescale 1ns/1ns

module flit_counter (
    input  logic                      clk,
    input  logic                      n_rst,
    input  logic                      clear,
    input  logic                      en,
    input  chiplet_tx_pkg::pkt_len_t  limit,
    output chiplet_tx_pkg::pkt_len_t  count,
    output logic                      done
);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (en) begin
            count <= count + 1'b1;
        end
    end

    // high on the last flit of the packet, so the push in this cycle ends it.
    assign done = (count == limit);

endmodule

// File: hw/flit_queue.sv
`timescale 1ns/1ns
`include "chiplet_tx_consts.svh"

module flit_queue (
    input  logic                   clk,
    input  logic                   n_rst,
    input  logic                   push,
    input  chiplet_tx_pkg::flit_t  push_flit,
    output logic                   full,
    output logic                   flit_valid,
    output chiplet_tx_pkg::flit_t  flit,
    input  logic                   flit_ready
);
    localparam int DEPTH = `QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    chiplet_tx_pkg::flit_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occupancy;
    logic pop;
    logic do_push;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full       = (occupancy == CNT_W'(DEPTH));
    assign flit_valid = (occupancy != '0);
    assign flit       = mem[rd_ptr];

    // a pop in the same cycle frees the entry a push needs.
    assign pop     = flit_valid && flit_ready;
    assign do_push = push && (!full || pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_flit;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !pop) begin
                occupancy <= occupancy + 1'b1;
            end else if (pop && !do_push) begin
                occupancy <= occupancy - 1'b1;
            end
        end
    end

endmodule

// File: hw/msg_table.sv
`timescale 1ns/1ns
`include "chiplet_tx_consts.svh"

module msg_table (
    input  logic                       clk,
    input  logic                       n_rst,
    input  chiplet_tx_pkg::slot_cfg_t  slot_cfg,
    input  logic                       send_req,
    input  chiplet_tx_pkg::slot_id_t   send_slot,
    output logic                       send_ack,
    input  logic                       sel_take,
    output logic                       sel_valid,
    output chiplet_tx_pkg::slot_id_t   sel_slot,
    output chiplet_tx_pkg::buf_addr_t  sel_start
);
    localparam int NUM_SLOTS = 1 << `SLOT_W;

    chiplet_tx_pkg::buf_addr_t start_addr [NUM_SLOTS];
    logic [NUM_SLOTS-1:0] pending;
    logic [NUM_SLOTS-1:0] next_pending;
    logic trigger;

    // a request counts once, on its rising phase while ack is still low.
    assign trigger = send_req && !send_ack;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            send_ack <= 1'b0;
        end else if (trigger) begin
            send_ack <= 1'b1;
        end else if (!send_req) begin
            send_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                start_addr[i] <= '0;
            end
        end else if (slot_cfg.en) begin
            start_addr[slot_cfg.slot] <= slot_cfg.start;
        end
    end

    // the host trigger is applied last so it wins over a take of the same slot.
    always_comb begin
        next_pending = pending;
        if (sel_take) begin
            next_pending[sel_slot] = 1'b0;
        end
        if (trigger) begin
            next_pending[send_slot] = 1'b1;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= '0;
        end else begin
            pending <= next_pending;
        end
    end

    // lowest pending slot first.
    always_comb begin
        sel_slot = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_slot = chiplet_tx_pkg::slot_id_t'(i);
            end
        end
    end

    assign sel_valid = |pending;
    assign sel_start = start_addr[sel_slot];

endmodule

// File: hw/pkt_buffer.sv
`timescale 1ns/1ns
`include "chiplet_tx_consts.svh"

module pkt_buffer (
    input  logic                       clk,
    input  logic                       n_rst,
    input  chiplet_tx_pkg::buf_wr_t    buf_wr,
    input  chiplet_tx_pkg::buf_addr_t  rd_addr,
    output chiplet_tx_pkg::word_t      rd_data
);
    localparam int DEPTH = 1 << `BUF_AW;

    chiplet_tx_pkg::word_t mem [DEPTH];
    logic wr_en;

    // ##########################################################################
    // host write port.
    // ##########################################################################

    // the host cannot load words while the endpoint is held in reset.
    assign wr_en = buf_wr.en && n_rst;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[buf_wr.addr] <= buf_wr.data;
        end
    end

    // ##########################################################################
    // transmit read port.
    // ##########################################################################

    // combinational read, so a same-cycle write to this address is seen only
    // on the following cycle.
    assign rd_data = mem[rd_addr];

endmodule

// File: hw/tx_fsm.sv
`timescale 1ns/1ns
`include "chiplet_tx_consts.svh"

module tx_fsm #(
    parameter chiplet_tx_pkg::node_id_t node_id = '0
) (
    input  logic                       clk,
    input  logic                       n_rst,
    input  logic                       sel_valid,
    input  chiplet_tx_pkg::slot_id_t   sel_slot,
    input  chiplet_tx_pkg::buf_addr_t  sel_start,
    output logic                       sel_take,
    output chiplet_tx_pkg::buf_addr_t  rd_addr,
    input  chiplet_tx_pkg::word_t      rd_data,
    output logic                       cnt_clear,
    output logic                       cnt_en,
    output chiplet_tx_pkg::pkt_len_t   cnt_limit,
    input  chiplet_tx_pkg::pkt_len_t   count,
    input  logic                       done,
    input  logic                       full,
    output logic                       push,
    output chiplet_tx_pkg::flit_t      push_flit
);

    typedef enum logic [1:0] {
        IDLE,
        START,
        SEND
    } state_e;

    state_e state;
    state_e next_state;

    chiplet_tx_pkg::slot_id_t  cur_slot;
    chiplet_tx_pkg::buf_addr_t cur_start;
    chiplet_tx_pkg::pkt_len_t  cur_len;

    // ##########################################################################
    // state register and per-packet context.
    // ##########################################################################

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // in START the header word is on rd_data, so its length field is latched.
    always_ff @(posedge clk) begin
        if (state == START) begin
            cur_slot  <= sel_slot;
            cur_start <= sel_start;
            cur_len   <= rd_data[`LEN_LSB +: `LEN_W];
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (sel_valid) begin
                    next_state = START;
                end
            end
            START: begin
                next_state = SEND;
            end
            SEND: begin
                if (push && done) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // ##########################################################################
    // outputs.
    // ##########################################################################

    // address wraps modulo the buffer size.
    always_comb begin
        if (state == SEND) begin
            rd_addr = cur_start + chiplet_tx_pkg::buf_addr_t'(count);
        end else begin
            rd_addr = sel_start;
        end
    end

    assign sel_take  = (state == START);
    assign cnt_clear = (state == START);
    assign cnt_limit = cur_len;

    // address and count hold while the queue is full.
    assign push   = (state == SEND) && !full;
    assign cnt_en = push;

    always_comb begin
        push_flit.vc      = '0;
        push_flit.id      = cur_slot;
        push_flit.src     = node_id;
        push_flit.payload = rd_data;
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line.
cd "$(dirname "$0")" \
    && verilator --binary -Wno-fatal -f chiplet_tx.f \
        --top-module chiplet_tx_tb -o chiplet_tx_sim \
    && ./obj_dir/chiplet_tx_sim | tee /dev/stderr | grep -qx "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tests/chiplet_tx_tb.sv
`timescale 1ns/1ns
`include "chiplet_tx_consts.svh"

module chiplet_tx_tb;

    localparam int READY_ON     = 0;
    localparam int READY_OFF    = 1;
    localparam int READY_RANDOM = 2;

    logic                      clk = 1'b0;
    logic                      n_rst;
    chiplet_tx_pkg::buf_wr_t   buf_wr;
    chiplet_tx_pkg::slot_cfg_t slot_cfg;
    logic                      send_req;
    chiplet_tx_pkg::slot_id_t  send_slot;
    logic                      send_ack;
    logic                      flit_valid;
    chiplet_tx_pkg::flit_t     flit;
    logic                      flit_ready;

    // reference copy of the buffer and the table, and the flits still owed.
    chiplet_tx_pkg::word_t     model_mem [1 << `BUF_AW];
    chiplet_tx_pkg::buf_addr_t start_cfg [1 << `SLOT_W];
    chiplet_tx_pkg::flit_t     exp_q [$];
    chiplet_tx_pkg::flit_t     exp_flit;

    logic [15:0] data_lfsr;
    logic [15:0] ready_lfsr;
    int          ready_mode;
    int          stall_left;
    int          total_flits;
    int          cycle_count;
    string       test_name;

    chiplet_tx #(
        .node_id (4'h5)
    ) u_dut (
        .clk        (clk),
        .n_rst      (n_rst),
        .buf_wr     (buf_wr),
        .slot_cfg   (slot_cfg),
        .send_req   (send_req),
        .send_slot  (send_slot),
        .send_ack   (send_ack),
        .flit_valid (flit_valid),
        .flit       (flit),
        .flit_ready (flit_ready)
    );

    always #10 clk = ~clk;

    // ##########################################################################
    // helpers.
    // ##########################################################################

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    function automatic logic [31:0] take_bits(inout logic [15:0] state, input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            bits = {bits[30:0], state[0]};
        end
        return bits;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        report_failure($sformatf("Fail %s %s: expected %0h, actual %0h",
                                 test_name, what, expected, actual));
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    // the header gets random upper bits and the given length field.
    task automatic load_packet(input chiplet_tx_pkg::buf_addr_t start,
                               input chiplet_tx_pkg::pkt_len_t len);
        chiplet_tx_pkg::buf_addr_t addr;
        chiplet_tx_pkg::word_t     word;
        addr = start;
        for (int i = 0; i <= int'(len); i++) begin
            word = take_bits(data_lfsr, 32);
            if (i == 0) begin
                word[`LEN_LSB +: `LEN_W] = len;
            end
            buf_wr.en = 1'b1;
            buf_wr.addr = addr;
            buf_wr.data = word;
            model_mem[addr] = word;
            step_cycle();
            addr = addr + 1'b1;
        end
        buf_wr.en = 1'b0;
    endtask

    task automatic config_slot(input chiplet_tx_pkg::slot_id_t slot,
                               input chiplet_tx_pkg::buf_addr_t start);
        slot_cfg.en = 1'b1;
        slot_cfg.slot = slot;
        slot_cfg.start = start;
        step_cycle();
        slot_cfg.en = 1'b0;
        start_cfg[slot] = start;
    endtask

    task automatic expect_packet(input chiplet_tx_pkg::slot_id_t slot);
        chiplet_tx_pkg::flit_t     f;
        chiplet_tx_pkg::buf_addr_t addr;
        chiplet_tx_pkg::pkt_len_t  len;
        addr = start_cfg[slot];
        len = model_mem[addr][`LEN_LSB +: `LEN_W];
        for (int i = 0; i <= int'(len); i++) begin
            f.vc = '0;
            f.id = slot;
            f.src = 4'h5;
            f.payload = model_mem[addr];
            exp_q.push_back(f);
            addr = addr + 1'b1;
        end
        total_flits += int'(len) + 1;
    endtask

    // the host keeps req up for two more cycles after it sees ack.
    task automatic send_trigger(input chiplet_tx_pkg::slot_id_t slot);
        send_req = 1'b1;
        send_slot = slot;
        step_cycle();
        while (!send_ack) begin
            step_cycle();
        end
        repeat (2) step_cycle();
        send_req = 1'b0;
        step_cycle();
        while (send_ack) begin
            step_cycle();
        end
    endtask

    // idle cycles after the drain catch any flit beyond the expected ones.
    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            step_cycle();
        end
        repeat (20) step_cycle();
    endtask

    // ##########################################################################
    // checkers, switch model and watchdog.
    // ##########################################################################

    assert property (@(posedge clk) disable iff (!n_rst)
        (!send_req && !send_ack) |=> !send_ack)
    else report_failure("send_ack rose while send_req was low");

    assert property (@(posedge clk) disable iff (!n_rst)
        (send_req && send_ack) |=> send_ack)
    else report_failure("send_ack dropped before the host released send_req");

    assert property (@(posedge clk) disable iff (!n_rst)
        (flit_valid && !flit_ready) |=> (flit_valid && $stable(flit)))
    else report_failure("the output flit changed while the switch stalled it");

    // valid and ready are settled at the falling edge before the transfer.
    always @(negedge clk) begin
        if (n_rst && flit_valid && flit_ready) begin
            if (exp_q.size() == 0) begin
                report_failure($sformatf("%s: a flit came out that no send asked for",
                                         test_name));
            end else begin
                exp_flit = exp_q.pop_front();
                assert (flit == exp_flit)
                else report_mismatch("flit", exp_flit, flit);
            end
        end
    end

    // long low stretches start when three random bits are all zero.
    always @(posedge clk) begin
        #2;
        if (ready_mode == READY_ON) begin
            flit_ready = 1'b1;
        end else if (ready_mode == READY_OFF) begin
            flit_ready = 1'b0;
        end else if (stall_left != 0) begin
            flit_ready = 1'b0;
            stall_left = stall_left - 1;
        end else if (take_bits(ready_lfsr, 3) == 0) begin
            flit_ready = 1'b0;
            stall_left = 4 + int'(take_bits(ready_lfsr, 4));
        end else begin
            flit_ready = take_bits(ready_lfsr, 1) != 0;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 40 * total_flits + 2000) begin
            report_failure($sformatf("timeout: the run did not finish in %0d cycles",
                                     cycle_count));
        end
    end

    // ##########################################################################
    // test sequence.
    // ##########################################################################

    initial begin
        chiplet_tx_pkg::buf_addr_t start;
        chiplet_tx_pkg::pkt_len_t  len;
        n_rst = 1'b0;
        buf_wr = '0;
        slot_cfg = '0;
        send_req = 1'b0;
        send_slot = '0;
        flit_ready = 1'b0;
        data_lfsr = 16'd60;
        ready_lfsr = 16'd60;
        ready_mode = READY_ON;
        stall_left = 0;
        total_flits = 0;
        cycle_count = 0;
        test_name = "reset_idle";
        repeat (2) @(posedge clk);
        #2;
        n_rst = 1'b1;
        repeat (8) begin
            step_cycle();
            assert (!send_ack) else report_mismatch("send_ack", 0, send_ack);
            assert (!flit_valid) else report_mismatch("flit_valid", 0, flit_valid);
        end

        // start 63 always wraps and packet 4 carries only its header.
        test_name = "single_packet";
        for (int k = 0; k < 6; k++) begin
            start = chiplet_tx_pkg::buf_addr_t'(k * 21);
            len = (k == 4) ? 4'd0 : chiplet_tx_pkg::pkt_len_t'(take_bits(data_lfsr, 4));
            if (k == 3) begin
                len[0] = 1'b1;
            end
            load_packet(start, len);
            config_slot(chiplet_tx_pkg::slot_id_t'(k), start);
            expect_packet(chiplet_tx_pkg::slot_id_t'(k));
            send_trigger(chiplet_tx_pkg::slot_id_t'(k));
            wait_drain();
        end

        // the second trigger of slot 2 lands while it is still pending.
        test_name = "repeat_trigger";
        ready_mode = READY_OFF;
        load_packet(6'd0, 4'd15);
        config_slot(2'd1, 6'd0);
        expect_packet(2'd1);
        send_trigger(2'd1);
        repeat (10) step_cycle();
        load_packet(6'd20, chiplet_tx_pkg::pkt_len_t'(take_bits(data_lfsr, 4)));
        config_slot(2'd2, 6'd20);
        expect_packet(2'd2);
        send_trigger(2'd2);
        send_trigger(2'd2);
        ready_mode = READY_ON;
        wait_drain();

        test_name = "priority";
        ready_mode = READY_OFF;
        for (int s = 0; s < 4; s++) begin
            start = chiplet_tx_pkg::buf_addr_t'(2 + 16 * s);
            len = (s == 0) ? 4'd15 : chiplet_tx_pkg::pkt_len_t'(take_bits(data_lfsr, 4));
            load_packet(start, len);
            config_slot(chiplet_tx_pkg::slot_id_t'(s), start);
        end
        expect_packet(2'd0);
        send_trigger(2'd0);
        repeat (10) step_cycle();
        expect_packet(2'd1);
        expect_packet(2'd2);
        expect_packet(2'd3);
        send_trigger(2'd3);
        send_trigger(2'd1);
        send_trigger(2'd2);
        ready_mode = READY_ON;
        wait_drain();

        test_name = "random_ready";
        ready_mode = READY_RANDOM;
        for (int r = 0; r < 4; r++) begin
            for (int s = 0; s < 4; s++) begin
                start = chiplet_tx_pkg::buf_addr_t'(16 * s + 4 * r);
                load_packet(start, chiplet_tx_pkg::pkt_len_t'(take_bits(data_lfsr, 4)));
                config_slot(chiplet_tx_pkg::slot_id_t'(s), start);
            end
            for (int s = 0; s < 4; s++) begin
                expect_packet(chiplet_tx_pkg::slot_id_t'(s));
                send_trigger(chiplet_tx_pkg::slot_id_t'(s));
            end
            wait_drain();
        end

        ready_mode = READY_ON;
        repeat (20) step_cycle();
        $display("TEST OK");
        $finish;
    end

endmodule
